// File: exu_alu.sv
`timescale 1ns/1ns

module exu_alu (
   input  logic                     clk,
   input  logic                     rst,
   input  exu_pkg::d2e_s            d2e,
   input  logic [exu_pkg::XLEN-1:0] opa,
   input  logic [exu_pkg::XLEN-1:0] opb,
   output logic                     br_taken,
   output logic [exu_pkg::XLEN-1:0] br_target,
   output exu_pkg::res_s            alu_res
);
   import exu_pkg::*;

   logic [XLEN-1:0] result;
   logic            equal;

   always_comb begin
      case (d2e.alu_op)
         ALU_ADD: result = opa + opb;
         ALU_SUB: result = opa - opb;
         ALU_AND: result = opa & opb;
         ALU_OR:  result = opa | opb;
         ALU_XOR: result = opa ^ opb;
         // signed compare
         ALU_SLT: result = {{(XLEN-1){1'b0}}, ($signed(opa) < $signed(opb))};
         default: result = '0;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // branch resolve, seen by dispatch in the same cycle
   ////////////////////////////////////////////////////////////////////////////

   assign equal     = (opa == opb);
   assign br_taken  = d2e.is_br & (d2e.is_bne ? ~equal : equal);

   // word offset
   assign br_target = d2e.pc + {d2e.imm[XLEN-3:0], 2'b00};

   // e to m
   always_ff @(posedge clk) begin
      alu_res.rd   <= d2e.rd;
      alu_res.data <= result;
      if (rst) begin
         alu_res.wen <= 1'b0;
      end else begin
         alu_res.wen <= d2e.is_alu & d2e.wen;
      end
   end

endmodule

// File: exu_bypass.sv
`timescale 1ns/1ns

module exu_bypass (
   input  exu_pkg::d2e_s            d2e,
   input  exu_pkg::res_s            res_m,
   input  exu_pkg::res_s            res_w,
   output logic [exu_pkg::XLEN-1:0] opa,
   output logic [exu_pkg::XLEN-1:0] opb
);
   import exu_pkg::*;

   logic [XLEN-1:0] fwd_b;

   // m holds the younger result so it is checked first
   function automatic logic [XLEN-1:0] pick (
      input logic [REG_ADDR_W-1:0] rs,
      input logic [XLEN-1:0]       rf_data,
      input res_s                  m,
      input res_s                  w
   );
      if (m.wen && (m.rd == rs)) begin
         return m.data;
      end
      if (w.wen && (w.rd == rs)) begin
         return w.data;
      end
      return rf_data;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // operand select in e
   ////////////////////////////////////////////////////////////////////////////

   assign opa   = pick(d2e.rs1, d2e.src_a, res_m, res_w);
   assign fwd_b = pick(d2e.rs2, d2e.src_b, res_m, res_w);

   // an immediate operand b is never replaced
   // store data and branch compare ride on opb
   assign opb   = d2e.use_imm ? d2e.src_b : fwd_b;

endmodule

// File: exu_dispatch.sv
`timescale 1ns/1ns

module exu_dispatch (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     inst_valid,
   input  exu_pkg::inst_word_u      inst,
   input  logic [exu_pkg::XLEN-1:0] pc,
   output logic                     inst_ready,
   input  logic                     lsu_busy,
   input  logic                     br_kill,
   input  exu_pkg::res_s            wb,
   output exu_pkg::d2e_s            d2e
);
   import exu_pkg::*;

   d2e_s            dec;
   logic            known;
   logic            accept;
   logic            rd_as_rs2;
   logic [XLEN-1:0] rs1_data;
   logic [XLEN-1:0] rs2_data;

   // issue stalls for the whole memory access
   assign inst_ready = ~lsu_busy;
   assign accept     = inst_valid & inst_ready;

   ////////////////////////////////////////////////////////////////////////////
   // decode
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      dec        = '0;
      known      = 1'b1;
      dec.alu_op = ALU_ADD;
      dec.rd     = inst.r_form.rd;
      dec.imm    = {{(XLEN-12){inst.i_form.imm[11]}}, inst.i_form.imm};
      dec.pc     = pc;
      case (inst.r_form.opcode)
         OPC_ADD:  dec.alu_op  = ALU_ADD;
         OPC_SUB:  dec.alu_op  = ALU_SUB;
         OPC_AND:  dec.alu_op  = ALU_AND;
         OPC_OR:   dec.alu_op  = ALU_OR;
         OPC_XOR:  dec.alu_op  = ALU_XOR;
         OPC_SLT:  dec.alu_op  = ALU_SLT;
         OPC_ADDI: dec.use_imm = 1'b1;
         OPC_LD_W: dec.is_ld   = 1'b1;
         OPC_ST_W: dec.is_st   = 1'b1;
         OPC_BEQ:  dec.is_br   = 1'b1;
         OPC_BNE:  dec.is_bne  = 1'b1;
         default:  known       = 1'b0;
      endcase
      dec.is_br  = dec.is_br | dec.is_bne;
      dec.is_alu = known & ~(dec.is_ld | dec.is_st | dec.is_br);

      // store data and branch compare come in on rd
      rd_as_rs2  = dec.is_st | dec.is_br;
      dec.rs1    = inst.r_form.rj;
      dec.rs2    = rd_as_rs2 ? inst.r_form.rd : inst.r_form.rk;

      // only ALU ops and loads write, never to r0
      dec.wen    = (dec.is_alu | dec.is_ld) & (inst.r_form.rd != '0);
   end

   exu_regfile u_regfile (
      .clk      (clk),
      .rst      (rst),
      .rs1      (dec.rs1),
      .rs2      (dec.rs2),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .wb       (wb)
   );

   // d to e register, a killed or missing instruction turns into a bubble
   always_ff @(posedge clk) begin
      d2e       <= dec;
      d2e.src_a <= rs1_data;
      d2e.src_b <= dec.use_imm ? dec.imm : rs2_data;
      if (rst || !accept || br_kill) begin
         d2e.is_alu <= 1'b0;
         d2e.is_ld  <= 1'b0;
         d2e.is_st  <= 1'b0;
         d2e.is_br  <= 1'b0;
         d2e.wen    <= 1'b0;
      end
   end

   a_known_opcode : assert property (@(posedge clk) disable iff (rst)
      accept |-> known);

endmodule

// File: exu_lsu.sv
`timescale 1ns/1ns

module exu_lsu (
   input  logic                     clk,
   input  logic                     rst,
   input  exu_pkg::d2e_s            d2e,
   input  logic [exu_pkg::XLEN-1:0] opa,
   input  logic [exu_pkg::XLEN-1:0] opb,
   output logic                     mem_req,
   output exu_pkg::mem_req_s        mem_req_data,
   input  logic                     mem_ack,
   input  logic [exu_pkg::XLEN-1:0] mem_rdata,
   output logic                     lsu_busy,
   output logic                     lsu_done,
   output exu_pkg::res_s            lsu_res
);
   import exu_pkg::*;

   logic [LSU_ST_W-1:0]   state;
   logic                  start;
   mem_req_s              req_d;
   mem_req_s              req_q;
   logic                  wen_q;
   logic [REG_ADDR_W-1:0] rd_q;
   logic [XLEN-1:0]       data_q;

   assign start = (state == LSU_IDLE) & (d2e.is_ld | d2e.is_st);

   // base plus offset
   assign req_d.we    = d2e.is_st;
   assign req_d.addr  = opa + d2e.imm;
   assign req_d.wdata = opb;

   // request goes out straight from e, then from the held copy
   assign mem_req      = start | (state == LSU_REQ);
   assign mem_req_data = (state == LSU_IDLE) ? req_d : req_q;
   assign lsu_busy     = start | (state != LSU_IDLE);
   assign lsu_done     = (state == LSU_REL) & ~mem_ack;
   assign lsu_res      = '{wen: wen_q, rd: rd_q, data: data_q};

   ////////////////////////////////////////////////////////////////////////////
   // four-phase handshake
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= LSU_IDLE;
         wen_q <= 1'b0;
      end else begin
         case (state)
            LSU_IDLE: begin
               if (start) begin
                  state <= LSU_REQ;
                  wen_q <= d2e.wen;
               end
            end
            LSU_REQ: begin
               if (mem_ack) begin
                  state <= LSU_REL;
               end
            end
            // wait for the responder to drop ack
            LSU_REL: begin
               if (!mem_ack) begin
                  state <= LSU_IDLE;
               end
            end
            default: state <= LSU_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         req_q <= req_d;
         rd_q  <= d2e.rd;
      end
      if ((state == LSU_REQ) && mem_ack) begin
         data_q <= mem_rdata;
      end
   end

   a_req_held : assert property (@(posedge clk) disable iff (rst)
      mem_req && !mem_ack |=> mem_req && $stable(mem_req_data));

endmodule

// File: exu_pkg.sv
package exu_pkg;

   localparam int XLEN       = 32;
   localparam int REG_ADDR_W = 5;
   localparam int NUM_REGS   = 32;
   localparam int OPC_W      = 10;
   localparam int ALU_OP_W   = 3;
   localparam int LSU_ST_W   = 2;

   // major opcodes, top ten bits of the word
   localparam logic [OPC_W-1:0] OPC_ADD  = 10'h001;
   localparam logic [OPC_W-1:0] OPC_SUB  = 10'h002;
   localparam logic [OPC_W-1:0] OPC_AND  = 10'h003;
   localparam logic [OPC_W-1:0] OPC_OR   = 10'h004;
   localparam logic [OPC_W-1:0] OPC_XOR  = 10'h005;
   localparam logic [OPC_W-1:0] OPC_SLT  = 10'h006;
   localparam logic [OPC_W-1:0] OPC_ADDI = 10'h00a;
   localparam logic [OPC_W-1:0] OPC_LD_W = 10'h0a2;
   localparam logic [OPC_W-1:0] OPC_ST_W = 10'h0a6;
   localparam logic [OPC_W-1:0] OPC_BEQ  = 10'h058;
   localparam logic [OPC_W-1:0] OPC_BNE  = 10'h05c;

   localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'd0;
   localparam logic [ALU_OP_W-1:0] ALU_SUB = 3'd1;
   localparam logic [ALU_OP_W-1:0] ALU_AND = 3'd2;
   localparam logic [ALU_OP_W-1:0] ALU_OR  = 3'd3;
   localparam logic [ALU_OP_W-1:0] ALU_XOR = 3'd4;
   localparam logic [ALU_OP_W-1:0] ALU_SLT = 3'd5;

   // load/store fsm
   localparam logic [LSU_ST_W-1:0] LSU_IDLE = 2'd0;
   localparam logic [LSU_ST_W-1:0] LSU_REQ  = 2'd1;
   localparam logic [LSU_ST_W-1:0] LSU_REL  = 2'd2;

   ////////////////////////////////////////////////////////////////////////////
   // instruction word, two views of the same 32 bits
   ////////////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic [OPC_W-1:0]      opcode;
      logic [6:0]            pad;
      logic [REG_ADDR_W-1:0] rk;
      logic [REG_ADDR_W-1:0] rj;
      logic [REG_ADDR_W-1:0] rd;
   } r_form_s;

   typedef struct packed {
      logic [OPC_W-1:0]      opcode;
      logic [11:0]           imm;
      logic [REG_ADDR_W-1:0] rj;
      logic [REG_ADDR_W-1:0] rd;
   } i_form_s;

   typedef union packed {
      r_form_s r_form;
      i_form_s i_form;
   } inst_word_u;

   ////////////////////////////////////////////////////////////////////////////
   // stage bundles
   ////////////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic                  is_alu;
      logic                  is_ld;
      logic                  is_st;
      logic                  is_br;
      logic                  is_bne;
      logic [ALU_OP_W-1:0]   alu_op;
      logic                  use_imm;
      logic [REG_ADDR_W-1:0] rs1;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rd;
      logic                  wen;
      logic [XLEN-1:0]       src_a;
      logic [XLEN-1:0]       src_b;
      logic [XLEN-1:0]       imm;
      logic [XLEN-1:0]       pc;
   } d2e_s;

   typedef struct packed {
      logic                  wen;
      logic [REG_ADDR_W-1:0] rd;
      logic [XLEN-1:0]       data;
   } res_s;

   typedef struct packed {
      logic            we;
      logic [XLEN-1:0] addr;
      logic [XLEN-1:0] wdata;
   } mem_req_s;

endpackage

// File: exu_regfile.sv
`timescale 1ns/1ns

module exu_regfile (
   input  logic                           clk,
   input  logic                           rst,
   input  logic [exu_pkg::REG_ADDR_W-1:0] rs1,
   input  logic [exu_pkg::REG_ADDR_W-1:0] rs2,
   output logic [exu_pkg::XLEN-1:0]       rs1_data,
   output logic [exu_pkg::XLEN-1:0]       rs2_data,
   input  exu_pkg::res_s                  wb
);
   import exu_pkg::*;

   logic [XLEN-1:0] regs [NUM_REGS];

   // writes held off while in reset
   always_ff @(posedge clk) begin
      if (!rst && wb.wen) begin
         regs[wb.rd] <= wb.data;
      end
   end

   // r0 reads as zero
   // a same-cycle write from w is returned directly
   assign rs1_data = (rs1 == '0)                ? '0      :
                     (wb.wen && (wb.rd == rs1)) ? wb.data :
                                                  regs[rs1];

   assign rs2_data = (rs2 == '0)                ? '0      :
                     (wb.wen && (wb.rd == rs2)) ? wb.data :
                                                  regs[rs2];

endmodule

// File: exu_top.sv
`timescale 1ns/1ns

module exu_top (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           inst_valid,
   input  exu_pkg::inst_word_u            inst,
   input  logic [exu_pkg::XLEN-1:0]       pc,
   output logic                           inst_ready,
   output logic                           mem_req,
   output exu_pkg::mem_req_s              mem_req_data,
   input  logic                           mem_ack,
   input  logic [exu_pkg::XLEN-1:0]       mem_rdata,
   output logic                           br_taken,
   output logic [exu_pkg::XLEN-1:0]       br_target,
   output logic                           wb_en,
   output logic [exu_pkg::REG_ADDR_W-1:0] wb_rd,
   output logic [exu_pkg::XLEN-1:0]       wb_data
);
   import exu_pkg::*;

   d2e_s            d2e;
   logic [XLEN-1:0] opa;
   logic [XLEN-1:0] opb;
   res_s            alu_res;
   res_s            lsu_res;
   res_s            res_m;
   res_s            res_w;
   logic            lsu_busy;
   logic            lsu_done;

   exu_dispatch u_dispatch (
      .clk (clk), .rst (rst), .inst_valid (inst_valid), .inst (inst), .pc (pc),
      .inst_ready (inst_ready), .lsu_busy (lsu_busy), .br_kill (br_taken),
      .wb (res_w), .d2e (d2e)
   );

   exu_bypass u_bypass (.d2e (d2e), .res_m (res_m), .res_w (res_w), .opa (opa), .opb (opb));

   exu_alu u_alu (
      .clk (clk), .rst (rst), .d2e (d2e), .opa (opa), .opb (opb),
      .br_taken (br_taken), .br_target (br_target), .alu_res (alu_res)
   );

   exu_lsu u_lsu (
      .clk (clk), .rst (rst), .d2e (d2e), .opa (opa), .opb (opb),
      .mem_req (mem_req), .mem_req_data (mem_req_data), .mem_ack (mem_ack),
      .mem_rdata (mem_rdata), .lsu_busy (lsu_busy), .lsu_done (lsu_done),
      .lsu_res (lsu_res)
   );

   exu_writeback u_writeback (
      .clk (clk), .rst (rst), .alu_res (alu_res), .lsu_res (lsu_res),
      .lsu_done (lsu_done), .res_m (res_m), .res_w (res_w)
   );

   // writeback port
   assign wb_en   = res_w.wen;
   assign wb_rd   = res_w.rd;
   assign wb_data = res_w.data;

endmodule

// File: exu_writeback.sv
`timescale 1ns/1ns

module exu_writeback (
   input  logic          clk,
   input  logic          rst,
   input  exu_pkg::res_s alu_res,
   input  exu_pkg::res_s lsu_res,
   input  logic          lsu_done,
   output exu_pkg::res_s res_m,
   output exu_pkg::res_s res_w
);

   // memory result claims the m slot in its done cycle
   assign res_m = lsu_done ? lsu_res : alu_res;

   ////////////////////////////////////////////////////////////////////////////
   // m to w
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      res_w.rd   <= res_m.rd;
      res_w.data <= res_m.data;
      if (rst) begin
         res_w.wen <= 1'b0;
      end else begin
         res_w.wen <= res_m.wen;
      end
   end

   // issue stall keeps ALU results out of the load's slot
   a_no_collision : assert property (@(posedge clk) disable iff (rst)
      !(lsu_done && alu_res.wen));

endmodule

// File: filelist.f
exu_pkg.sv
exu_regfile.sv
exu_dispatch.sv
exu_bypass.sv
exu_alu.sv
exu_lsu.sv
exu_writeback.sv
exu_top.sv
tb_exu.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the execute-stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_exu
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

output="$(./obj_dir/Vtb_exu)"
status=$?
echo "$output"

if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "Done: no errors"; then
   exit 0
fi
exit 1

// File: tb_exu.sv
`timescale 1ns/1ns

module tb_exu;
   import exu_pkg::*;

   logic            clk;
   logic            rst;
   logic            inst_valid;
   inst_word_u      inst;
   logic [31:0]     pc;
   logic            inst_ready;
   logic            mem_req;
   mem_req_s        mem_req_data;
   logic            mem_ack;
   logic [31:0]     mem_rdata;
   logic            br_taken;
   logic [31:0]     br_target;
   logic            wb_en;
   logic [4:0]      wb_rd;
   logic [31:0]     wb_data;

   // stimulus table with one row per instruction
   logic [31:0] t_inst [32];
   logic        t_kill [32];
   logic        t_wr   [32];
   logic [4:0]  t_rd   [32];
   logic [31:0] t_data [32];
   logic        t_br   [32];
   logic        t_tk   [32];
   logic        t_mem  [32];
   logic [31:0] t_addr [32];
   int          n_steps;

   logic [36:0] exp_q [$];
   logic [31:0] mem [16];
   logic [31:0] mem_addr_exp;
   logic [31:0] mem_data_exp;
   logic        mem_we_exp;
   int          seed;

   exu_top dut (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
         $display("Done: errors found");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("Done: errors found");
      $fatal(1, "run aborted");
   endtask

   function automatic logic [31:0] r_inst(input logic [9:0] opc, input logic [4:0] rk,
                                          input logic [4:0] rj, input logic [4:0] rd);
      return {opc, 7'b0, rk, rj, rd};
   endfunction

   function automatic logic [31:0] i_inst(input logic [9:0] opc, input logic [11:0] imm,
                                          input logic [4:0] rj, input logic [4:0] rd);
      return {opc, imm, rj, rd};
   endfunction

   task automatic add_step(input logic [31:0] word, input logic wr, input logic [4:0] rd,
                           input logic [31:0] data, input logic kill, input logic br,
                           input logic tk, input logic is_mem, input logic [31:0] addr);
      t_inst[n_steps] = word;
      t_wr[n_steps]   = wr;
      t_rd[n_steps]   = rd;
      t_data[n_steps] = data;
      t_kill[n_steps] = kill;
      t_br[n_steps]   = br;
      t_tk[n_steps]   = tk;
      t_mem[n_steps]  = is_mem;
      t_addr[n_steps] = addr;
      n_steps++;
   endtask

   // wait up to 3 cycles, then drive on the next rising edge
   task automatic rand_delay();
      int d;
      d = int'($unsigned($random(seed)) % 4);
      repeat (d) @(posedge clk);
      @(posedge clk);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // memory responder and writeback monitor
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      int i;
      for (i = 0; i < 16; i++) mem[i] = 32'ha5a5_0000 | (i * 4);
      forever begin
         @(negedge clk);
         if (mem_req && !mem_ack) begin
            check("mem_req_data.addr", mem_req_data.addr, mem_addr_exp);
            check("mem_req_data.we", 32'(mem_req_data.we), 32'(mem_we_exp));
            if (mem_we_exp) check("mem_req_data.wdata", mem_req_data.wdata, mem_data_exp);
            rand_delay();
            mem_ack   <= 1'b1;
            mem_rdata <= mem[mem_req_data.addr[5:2]];
            if (mem_req_data.we) mem[mem_req_data.addr[5:2]] <= mem_req_data.wdata;
            i = 0;
            do begin
               @(negedge clk);
               i++;
               if (i > 20) stop_run("timeout: mem_req never dropped after mem_ack");
            end while (mem_req);
            rand_delay();
            mem_ack <= 1'b0;
         end
      end
   end

   initial begin
      logic [36:0] e;
      forever begin
         @(negedge clk);
         if (!rst && wb_en) begin
            if (exp_q.size() == 0) stop_run("unexpected write on the writeback port");
            e = exp_q.pop_front();
            check("wb_rd", 32'(wb_rd), 32'(e[36:32]));
            check("wb_data", wb_data, e[31:0]);
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      int i;
      int t;
      int br_step;
      logic [31:0] tgt;
      logic pending;
      logic ack_prev;
      seed = 32'h984;
      n_steps = 0;
      pending = 1'b0;
      ack_prev = 1'b0;
      rst = 1'b1;
      inst_valid = 1'b0;
      inst = '0;
      pc = '0;
      mem_ack = 1'b0;
      mem_rdata = '0;
      // constants and bypass from m and w
      add_step(i_inst(OPC_ADDI, 12'd5, 5'd0, 5'd1), 1, 1, 32'd5, 0, 0, 0, 0, 0);
      add_step(i_inst(OPC_ADDI, -12'sd3, 5'd0, 5'd2), 1, 2, 32'hffff_fffd, 0, 0, 0, 0, 0);
      add_step(r_inst(OPC_ADD, 5'd2, 5'd1, 5'd3), 1, 3, 32'd2, 0, 0, 0, 0, 0);
      add_step(r_inst(OPC_SUB, 5'd1, 5'd3, 5'd4), 1, 4, 32'hffff_fffd, 0, 0, 0, 0, 0);
      add_step(i_inst(OPC_ADDI, 12'd12, 5'd0, 5'd5), 1, 5, 32'd12, 0, 0, 0, 0, 0);
      add_step(r_inst(OPC_OR, 5'd5, 5'd4, 5'd6), 1, 6, 32'hffff_fffd, 0, 0, 0, 0, 0);
      add_step(r_inst(OPC_SLT, 5'd1, 5'd2, 5'd7), 1, 7, 32'd1, 0, 0, 0, 0, 0);
      add_step(r_inst(OPC_AND, 5'd5, 5'd6, 5'd8), 1, 8, 32'd12, 0, 0, 0, 0, 0);
      add_step(r_inst(OPC_XOR, 5'd1, 5'd5, 5'd16), 1, 16, 32'd9, 0, 0, 0, 0, 0);
      // store sees r9 in both m and w and takes the newer one
      add_step(i_inst(OPC_ADDI, 12'd3, 5'd0, 5'd9), 1, 9, 32'd3, 0, 0, 0, 0, 0);
      add_step(i_inst(OPC_ADDI, 12'd8, 5'd0, 5'd9), 1, 9, 32'd8, 0, 0, 0, 0, 0);
      add_step(i_inst(OPC_ST_W, 12'd4, 5'd9, 5'd6), 0, 0, 32'hffff_fffd, 0, 0, 0, 1, 12);
      add_step(i_inst(OPC_LD_W, 12'd4, 5'd9, 5'd10), 1, 10, 32'hffff_fffd, 0, 0, 0, 1, 12);
      add_step(i_inst(OPC_ADDI, 12'd1, 5'd10, 5'd11), 1, 11, 32'hffff_fffe, 0, 0, 0, 0, 0);
      // taken branches kill the next entry
      add_step(i_inst(OPC_BEQ, 12'd3, 5'd1, 5'd1), 0, 0, 0, 0, 1, 1, 0, 0);
      add_step(i_inst(OPC_ADDI, 12'd7, 5'd0, 5'd12), 1, 12, 32'd7, 1, 0, 0, 0, 0);
      add_step(i_inst(OPC_BNE, -12'sd2, 5'd1, 5'd2), 0, 0, 0, 0, 1, 1, 0, 0);
      add_step(i_inst(OPC_ADDI, 12'd9, 5'd0, 5'd13), 1, 13, 32'd9, 1, 0, 0, 0, 0);
      add_step(i_inst(OPC_BEQ, 12'd5, 5'd1, 5'd2), 0, 0, 0, 0, 1, 0, 0, 0);
      add_step(i_inst(OPC_ADDI, 12'd9, 5'd0, 5'd14), 1, 14, 32'd9, 0, 0, 0, 0, 0);
      // r0 as destination and as source
      add_step(i_inst(OPC_ADDI, 12'd1, 5'd1, 5'd0), 0, 0, 0, 0, 0, 0, 0, 0);
      add_step(r_inst(OPC_ADD, 5'd1, 5'd0, 5'd15), 1, 15, 32'd5, 0, 0, 0, 0, 0);
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      br_step = -1;
      for (i = 0; i < n_steps; i++) begin
         inst_valid <= 1'b1;
         inst       <= t_inst[i];
         pc         <= 32'h100 + 32'(i * 4);
         t = 0;
         do begin
            @(negedge clk);
            // issue stays stalled until the cycle after ack has fallen
            if (pending || mem_ack || ack_prev) begin
               check("inst_ready", 32'(inst_ready), 32'd0);
            end
            if (mem_ack) pending = 1'b0;
            ack_prev = mem_ack;
            if (br_step >= 0) begin
               tgt = 32'h100 + 32'(br_step * 4) + 32'(4 * $signed(t_inst[br_step][21:10]));
               check("br_taken", 32'(br_taken), 32'(t_tk[br_step]));
               if (t_tk[br_step]) check("br_target", br_target, tgt);
               br_step = -1;
            end
            t++;
            if (t > 60) stop_run("timeout: inst_ready stayed low");
         end while (!inst_ready);
         if (t_mem[i]) begin
            mem_addr_exp = t_addr[i];
            mem_data_exp = t_data[i];
            mem_we_exp   = !t_wr[i];
         end
         @(posedge clk);
         if (t_mem[i]) pending = 1'b1;
         if (t_wr[i] && !t_kill[i]) exp_q.push_back({t_rd[i], t_data[i]});
         if (t_br[i]) br_step = i;
      end
      inst_valid <= 1'b0;
      t = 0;
      while (exp_q.size() != 0) begin
         @(negedge clk);
         t++;
         if (t > 60) stop_run("timeout: expected writebacks never arrived");
      end
      repeat (8) @(posedge clk);
      $display("Done: no errors");
      $finish;
   end

endmodule
